//--- hdl/front_end_consts.svh
`ifndef FRONT_END_CONSTS_SVH
`define FRONT_END_CONSTS_SVH

`define FE_XLEN      32
`define FE_RESET_PC  32'h0000_0000

// opcode field
`define FE_OP_MSB    31
`define FE_OP_LSB    26
`define FE_OP_BRANCH 6'h04
`define FE_OP_NOP    6'h00  // all-zero word, writes nothing

// register fields: rs 25:21, rt 20:16, rd 15:11 (rd is the destination)
`define FE_RS_MSB    25
`define FE_RS_LSB    21
`define FE_RT_MSB    20
`define FE_RT_LSB    16
`define FE_RD_MSB    15
`define FE_RD_LSB    11

`endif

//--- hdl/front_end_pkg.sv
`default_nettype none
`include "front_end_consts.svh"

package front_end_pkg;

    typedef enum logic [1:0] {
        cls_alu    = 2'd0,
        cls_branch = 2'd1,
        cls_nop    = 2'd2
    } inst_class_e;

    typedef enum logic [1:0] {
        st_run       = 2'd0,
        st_slot_wait = 2'd1,  // branch issued, delay slot still owed
        st_redirect  = 2'd2
    } issue_state_e;

    // two consecutive words as returned by imem
    typedef struct packed {
        logic                ok1;
        logic                ok2;
        logic [`FE_XLEN-1:0] addr1;
        logic [`FE_XLEN-1:0] addr2;
        logic [`FE_XLEN-1:0] data1;
        logic [`FE_XLEN-1:0] data2;
    } fetch_pair_t;

    typedef struct packed {
        logic                ok;
        logic [`FE_XLEN-1:0] addr;
        logic [`FE_XLEN-1:0] data;
        logic                in_delayslot;
    } issue_slot_t;

endpackage

`default_nettype wire

//--- hdl/fetch_pair.sv
`timescale 1ns/1ns
`default_nettype none
`include "front_end_consts.svh"

module fetch_pair (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ena1,
    input  logic                        redirect,
    input  logic [`FE_XLEN-1:0]         redirect_target,
    output logic [`FE_XLEN-1:0]         imem_addr,
    input  logic [`FE_XLEN-1:0]         imem_data1,
    input  logic [`FE_XLEN-1:0]         imem_data2,
    input  logic                        imem_ok1,
    input  logic                        imem_ok2,
    output front_end_pkg::fetch_pair_t  fetch
);
    localparam logic [`FE_XLEN-1:0] WORD_BYTES = 4;

    logic [`FE_XLEN-1:0] pc;
    logic [`FE_XLEN-1:0] step;

    // advance by however many words the pair register took
    always_comb begin
        case ({imem_ok1, imem_ok2})
            2'b11:        step = WORD_BYTES << 1;
            2'b10, 2'b01: step = WORD_BYTES;
            default:      step = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FE_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_target;  // wins over a same-cycle advance
        end else if (ena1) begin
            pc <= pc + step;
        end
    end

    assign imem_addr = pc;

    always_comb begin
        fetch.ok1   = imem_ok1;
        fetch.ok2   = imem_ok2;
        fetch.addr1 = pc;
        fetch.addr2 = pc + WORD_BYTES;
        fetch.data1 = imem_data1;
        fetch.data2 = imem_data2;
    end

endmodule

`default_nettype wire

//--- hdl/if_id.sv
`timescale 1ns/1ns
`default_nettype none
`include "front_end_consts.svh"

module if_id (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        delay_hold,
    input  logic                        master_is_branch,
    input  logic                        ena1,
    input  logic                        ena2,
    input  front_end_pkg::fetch_pair_t  fetch,
    output front_end_pkg::issue_slot_t  master,
    output front_end_pkg::issue_slot_t  slave,
    output logic                        occupy
);
    // saved pair
    logic                ok1_q;
    logic                ok2_q;
    logic [`FE_XLEN-1:0] addr1_q;
    logic [`FE_XLEN-1:0] addr2_q;
    logic [`FE_XLEN-1:0] data1_q;
    logic [`FE_XLEN-1:0] data2_q;

    logic [`FE_XLEN-1:0] occ_addr;
    logic [`FE_XLEN-1:0] occ_data;

    logic                dly_en;
    logic [`FE_XLEN-1:0] dly_addr;
    logic [`FE_XLEN-1:0] dly_data;

    logic                in_delayslot;
    logic                load;

    // while occupy presents, the saved pair is still unissued
    assign load = ena1 && !occupy;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ok1_q <= 1'b0;
            ok2_q <= 1'b0;
        end else if (load) begin
            ok1_q <= fetch.ok1 || fetch.ok2;
            ok2_q <= fetch.ok1 && fetch.ok2;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (fetch.ok1) begin
                addr1_q <= fetch.addr1;
                data1_q <= fetch.data1;
            end else begin
                addr1_q <= fetch.addr2;  // lone second word moves up
                data1_q <= fetch.data2;
            end
            addr2_q <= fetch.addr2;
            data2_q <= fetch.data2;
        end
    end

    // slave left behind by an issuing master becomes the next master
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupy <= 1'b0;
        end else if (ena1 && master.ok && slave.ok && !ena2) begin
            occupy <= 1'b1;
        end else if (ena1) begin
            occupy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ena1 && !ena2) begin
            occ_addr <= slave.addr;
            occ_data <= slave.data;
        end
    end

    // delay slot kept alive across the redirect flush
    always_ff @(posedge clk) begin
        if (rst) begin
            dly_en <= 1'b0;
        end else if (delay_hold && !ena1) begin
            dly_en <= master.ok;
        end else if (ena1) begin
            dly_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (delay_hold && !ena1) begin
            dly_addr <= master.addr;
            dly_data <= master.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_delayslot <= 1'b0;
        end else if (ena1) begin
            in_delayslot <= master_is_branch && !ena2;
        end
    end

    always_comb begin
        master = '0;
        slave  = '0;
        if (dly_en) begin
            master.ok   = 1'b1;
            master.addr = dly_addr;
            master.data = dly_data;
        end else if (occupy) begin
            master.ok   = 1'b1;
            master.addr = occ_addr;
            master.data = occ_data;
        end else begin
            master.ok   = ok1_q;
            master.addr = addr1_q;
            master.data = data1_q;
            slave.ok    = ok2_q;
            slave.addr  = addr2_q;
            slave.data  = data2_q;
        end
        master.in_delayslot = in_delayslot;
    end

endmodule

`default_nettype wire

//--- hdl/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "front_end_consts.svh"

module issue_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        redirect,
    input  front_end_pkg::issue_slot_t  master,
    input  front_end_pkg::issue_slot_t  slave,
    input  logic                        occupy,
    output logic                        ena1,
    output logic                        ena2,
    output logic                        flush,
    output logic                        delay_hold,
    output logic                        master_is_branch
);
    front_end_pkg::issue_state_e state;
    front_end_pkg::issue_state_e state_nxt;
    front_end_pkg::inst_class_e  m_cls;
    front_end_pkg::inst_class_e  s_cls;

    logic [4:0] m_rd;
    logic [4:0] s_rs;
    logic [4:0] s_rt;
    logic       raw_hazard;
    logic       slot_owed;

    function automatic front_end_pkg::inst_class_e classify(input logic [`FE_XLEN-1:0] word);
        logic [`FE_OP_MSB-`FE_OP_LSB:0] op;
        op = word[`FE_OP_MSB:`FE_OP_LSB];
        if (op == `FE_OP_BRANCH) begin
            return front_end_pkg::cls_branch;
        end else if (op == `FE_OP_NOP) begin
            return front_end_pkg::cls_nop;
        end
        return front_end_pkg::cls_alu;
    endfunction

    assign m_cls = classify(master.data);
    assign s_cls = classify(slave.data);

    assign m_rd = master.data[`FE_RD_MSB:`FE_RD_LSB];
    assign s_rs = slave.data[`FE_RS_MSB:`FE_RS_LSB];
    assign s_rt = slave.data[`FE_RT_MSB:`FE_RT_LSB];

    // r0 never carries a dependency
    assign raw_hazard = (m_cls == front_end_pkg::cls_alu) && (m_rd != 5'd0)
                     && ((m_rd == s_rs) || (m_rd == s_rt));

    assign slot_owed        = (state == front_end_pkg::st_slot_wait);
    assign master_is_branch = master.ok && (m_cls == front_end_pkg::cls_branch);
    assign flush            = redirect;
    assign delay_hold       = redirect && slot_owed;

    // an empty master simply drops out on ena1
    assign ena1 = !stall && (state != front_end_pkg::st_redirect) && !delay_hold;
    assign ena2 = ena1 && master.ok && slave.ok && !occupy
               && (m_cls != front_end_pkg::cls_branch)
               && (s_cls != front_end_pkg::cls_branch)
               && !raw_hazard;

    always_comb begin
        state_nxt = state;
        case (state)
            front_end_pkg::st_run: begin
                if (!redirect && ena1 && master_is_branch) begin
                    state_nxt = front_end_pkg::st_slot_wait;
                end
            end
            front_end_pkg::st_slot_wait: begin
                if (delay_hold) begin
                    state_nxt = front_end_pkg::st_redirect;
                end else if (ena1 && master.ok) begin
                    state_nxt = front_end_pkg::st_run;  // delay slot went out
                end
            end
            default: state_nxt = front_end_pkg::st_run;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= front_end_pkg::st_run;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dual_front_end.sv
`timescale 1ns/1ns
`default_nettype none
`include "front_end_consts.svh"

module dual_front_end (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        redirect,
    input  logic [`FE_XLEN-1:0]         redirect_target,
    output logic [`FE_XLEN-1:0]         imem_addr,
    input  logic [`FE_XLEN-1:0]         imem_data1,
    input  logic [`FE_XLEN-1:0]         imem_data2,
    input  logic                        imem_ok1,
    input  logic                        imem_ok2,
    output front_end_pkg::issue_slot_t  issue0,
    output front_end_pkg::issue_slot_t  issue1
);
    front_end_pkg::fetch_pair_t fetch;
    front_end_pkg::issue_slot_t master;
    front_end_pkg::issue_slot_t slave;

    logic occupy;
    logic ena1;
    logic ena2;
    logic flush;
    logic delay_hold;
    logic master_is_branch;
    logic take;

    assign take = ena1 && !occupy;  // same condition the pair register loads on

    fetch_pair u_fetch (
        .clk             (clk),
        .rst             (rst),
        .ena1            (take),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .imem_addr       (imem_addr),
        .imem_data1      (imem_data1),
        .imem_data2      (imem_data2),
        .imem_ok1        (imem_ok1),
        .imem_ok2        (imem_ok2),
        .fetch           (fetch)
    );

    if_id u_if_id (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .delay_hold       (delay_hold),
        .master_is_branch (master_is_branch),
        .ena1             (ena1),
        .ena2             (ena2),
        .fetch            (fetch),
        .master           (master),
        .slave            (slave),
        .occupy           (occupy)
    );

    issue_ctrl u_issue (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .redirect         (redirect),
        .master           (master),
        .slave            (slave),
        .occupy           (occupy),
        .ena1             (ena1),
        .ena2             (ena2),
        .flush            (flush),
        .delay_hold       (delay_hold),
        .master_is_branch (master_is_branch)
    );

    always_comb begin
        issue0    = master;
        issue0.ok = master.ok && ena1;
        issue1    = slave;
        issue1.ok = slave.ok && ena2;
    end

endmodule

`default_nettype wire

//--- dv/dual_front_end_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "front_end_consts.svh"

module dual_front_end_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       stall,
    input logic                       redirect,
    input front_end_pkg::issue_slot_t issue0,
    input front_end_pkg::issue_slot_t issue1
);
    a_slave_needs_master: assert property (@(posedge clk) disable iff (rst)
        issue1.ok |-> issue0.ok)
        else $error("issue1 valid without issue0");

    a_quiet_in_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !issue0.ok && !issue1.ok)
        else $error("issue while stalled");

    // branches only ever go out on the master slot
    a_no_slave_branch: assert property (@(posedge clk) disable iff (rst)
        issue1.ok |-> issue1.data[`FE_OP_MSB:`FE_OP_LSB] != `FE_OP_BRANCH)
        else $error("branch issued on slot 1");

    a_gap_after_redirect: assert property (@(posedge clk) disable iff (rst)
        $past(redirect) |-> !issue0.ok && !issue1.ok)
        else $error("issue in the cycle after redirect");

endmodule

bind dual_front_end dual_front_end_checker chk (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .redirect (redirect),
    .issue0   (issue0),
    .issue1   (issue1)
);

`default_nettype wire

//--- dv/dual_front_end_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "front_end_consts.svh"

module dual_front_end_tb;
    localparam int IMG_WORDS  = 32;
    localparam int EVT_BASE   = 32;
    localparam int EXP_BASE   = 40;
    localparam int GOLD_WORDS = 64;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       stall;
    logic                       redirect;
    logic [`FE_XLEN-1:0]        redirect_target;
    logic [`FE_XLEN-1:0]        imem_addr;
    logic [`FE_XLEN-1:0]        imem_data1;
    logic [`FE_XLEN-1:0]        imem_data2;
    logic                       imem_ok1;
    logic                       imem_ok2;
    logic [`FE_XLEN-1:0]        idx1;
    front_end_pkg::issue_slot_t issue0;
    front_end_pkg::issue_slot_t issue1;

    logic [31:0] gold [0:GOLD_WORDS-1];

    int errors = 0;
    int issued = 0;
    int exp_count;
    int stall_left = 0;
    int stall_quiet = 0;
    int cycles;
    int mark;
    bit stall_done = 1'b0;
    bit redirect_next = 1'b0;

    always #4 clk = ~clk;

    // second word drops out past the end of the image
    assign idx1       = imem_addr >> 2;
    assign imem_ok1   = idx1 < IMG_WORDS;
    assign imem_ok2   = (idx1 + 1) < IMG_WORDS;
    assign imem_data1 = imem_ok1 ? gold[idx1[5:0]] : '0;
    assign imem_data2 = imem_ok2 ? gold[idx1[5:0] + 6'd1] : '0;

    dual_front_end uut (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .imem_addr       (imem_addr),
        .imem_data1      (imem_data1),
        .imem_data2      (imem_data2),
        .imem_ok1        (imem_ok1),
        .imem_ok2        (imem_ok2),
        .issue0          (issue0),
        .issue1          (issue1)
    );

    task automatic check_slot(input front_end_pkg::issue_slot_t s, input int num);
        logic [31:0] exp;
        logic [31:0] exp_data;
        if (!s.ok) begin
            return;
        end
        assert (issued < exp_count) else begin
            $display("unexpected extra issue of address %h on slot %0d", s.addr, num);
            errors++;
        end
        if (issued < exp_count) begin
            exp      = gold[EXP_BASE + issued];
            exp_data = gold[exp[7:2]];  // image word at the expected address
            assert (s.addr == {16'h0, exp[15:0]}) else begin
                $display("FAILED issue%0d.addr: got %h expected %h", num, s.addr, exp[15:0]);
                errors++;
            end
            assert (s.data == exp_data) else begin
                $display("FAILED issue%0d.data: got %h expected %h", num, s.data, exp_data);
                errors++;
            end
            assert (num == int'(exp[16])) else begin
                $display("FAILED issue slot of %h: got %h expected %h", s.addr, num, exp[16]);
                errors++;
            end
            assert (s.in_delayslot == exp[20]) else begin
                $display("FAILED issue%0d.in_delayslot: got %h expected %h",
                         num, s.in_delayslot, exp[20]);
                errors++;
            end
        end
        if (s.addr == gold[EVT_BASE + 2]) begin
            redirect_next = 1'b1;
        end
        issued++;
    endtask

    // drive on the falling edge and sample once outputs settle
    task automatic step_cycle();
        @(negedge clk);
        stall = (stall_left > 0);
        if (stall_left > 0) begin
            stall_left--;
        end
        redirect = redirect_next;
        if (redirect_next) begin
            redirect_target = gold[EVT_BASE + 3];
        end
        redirect_next = 1'b0;
        #1;
        if (stall) begin
            assert (!issue0.ok && !issue1.ok) else begin
                $display("something issued during stall at issue count %0d", issued);
                errors++;
            end
            if (!issue0.ok && !issue1.ok) begin
                stall_quiet++;
            end
        end
        check_slot(issue0, 0);
        check_slot(issue1, 1);
        if (!stall_done && issued >= gold[EVT_BASE]) begin
            stall_left = gold[EVT_BASE + 1];
            stall_done = 1'b1;
        end
    endtask

    initial begin
        rst             = 1'b1;
        stall           = 1'b0;
        redirect        = 1'b0;
        redirect_target = '0;
        $readmemh("dv/dual_front_end_golden.txt", gold);
        exp_count = gold[EVT_BASE + 4];
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // first word out of reset
        // counts rising edges up to the one that takes the first issue
        mark   = errors;
        cycles = 1;
        while (issued == 0 && cycles < 16) begin
            step_cycle();
            cycles++;
        end
        assert (issued > 0) else begin
            $display("timed out waiting for the first issue after reset");
            errors++;
        end
        assert (cycles == 2) else begin
            $display("FAILED reset to first issue cycles: got %h expected %h", cycles, 2);
            errors++;
        end
        $display("test reset: %0d errors", errors - mark);

        mark   = errors;
        cycles = 0;
        while (issued < exp_count && cycles < 200) begin
            step_cycle();
            cycles++;
        end
        assert (issued >= exp_count) else begin
            $display("timed out with %0d of %0d expected issues seen", issued, exp_count);
            errors++;
        end
        $display("test issue stream: %0d errors", errors - mark);

        mark = errors;
        assert (stall_done && stall_quiet == gold[EVT_BASE + 1]) else begin
            $display("issue outputs were not quiet for every cycle of the stall");
            errors++;
        end
        $display("test stall: %0d errors", errors - mark);

        // nothing past the image may issue
        mark = errors;
        repeat (16) step_cycle();
        $display("test drain: %0d errors", errors - mark);

        $display("tests: 4, issues: %0d, errors: %0d", issued, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/dual_front_end_golden.txt
// image words 0x00..0x1f, events at 0x20, expected issue stream from 0x28
// expected word: bit 20 delay-slot flag, bit 16 slot number, bits 15:0 address
@00
20430800 20a62000 21093800 20e05000
10200005 218d5800 20227000 20807800
22328000 22959800 1060000b 20000800
20001000 20001000 20001000 20001000
20001000 20001000 20001000 20001000
20430800 20641000 00000000 20002800
20000800 20001000 20001800 20002000
20002800 20003000 20003800 20004000
// stall at issue count, stall cycles, redirect after address, target, expected count
@20
00000008 00000003 00000028 00000050 00000018
@28
00000000 00010004 00000008 0000000c
00000010 00100014 00000018 0001001c
00000020 00010024 00000028 0010002c
00000050 00010054 00000058 0001005c
00000060 00010064 00000068 0001006c
00000070 00010074 00000078 0001007c

//--- dual_front_end.f
+incdir+hdl
hdl/front_end_pkg.sv
hdl/fetch_pair.sv
hdl/if_id.sv
hdl/issue_ctrl.sv
hdl/dual_front_end.sv
dv/dual_front_end_checker.sv
dv/dual_front_end_tb.sv

//--- run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module dual_front_end_tb \
    -f dual_front_end.f -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
